// File: hw/regfile_pkg.sv
/*
 * Shared definitions for the register bank pipeline: sizes, MIPS opcode and
 * funct encodings, ALU operations and the two views of an instruction word
 */
package regfile_pkg;

	// Datapath and register file sizes
	localparam int NB_DATA    = 32;
	localparam int NB_REG     = 5;
	localparam int N_REGISTER = 32;

	// Instruction field widths
	localparam int NB_OPCODE = 6;
	localparam int NB_FUNCT  = 6;
	localparam int NB_SHAMT  = 5;
	localparam int NB_IMM    = 16;

	typedef logic [NB_DATA-1:0] word_t;
	typedef logic [NB_REG-1:0]  reg_addr_t;

	// Primary opcodes
	localparam logic [NB_OPCODE-1:0] OPC_RTYPE = 6'h00;
	localparam logic [NB_OPCODE-1:0] OPC_ADDI  = 6'h08;
	localparam logic [NB_OPCODE-1:0] OPC_ANDI  = 6'h0c;
	localparam logic [NB_OPCODE-1:0] OPC_ORI   = 6'h0d;
	localparam logic [NB_OPCODE-1:0] OPC_XORI  = 6'h0e;
	localparam logic [NB_OPCODE-1:0] OPC_LUI   = 6'h0f;

	// R-type funct codes
	localparam logic [NB_FUNCT-1:0] FN_ADD = 6'h20;
	localparam logic [NB_FUNCT-1:0] FN_SUB = 6'h22;
	localparam logic [NB_FUNCT-1:0] FN_AND = 6'h24;
	localparam logic [NB_FUNCT-1:0] FN_OR  = 6'h25;
	localparam logic [NB_FUNCT-1:0] FN_XOR = 6'h26;
	localparam logic [NB_FUNCT-1:0] FN_SLT = 6'h2a;

	// Operations the execute stage knows
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5,
		ALU_LUI = 3'd6
	} alu_op_t;

	// Register format, three register fields plus funct
	typedef struct packed {
		logic [NB_OPCODE-1:0] opcode;
		reg_addr_t            rs;
		reg_addr_t            rt;
		reg_addr_t            rd;
		logic [NB_SHAMT-1:0]  shamt;
		logic [NB_FUNCT-1:0]  funct;
	} r_fields_t;

	// Immediate format, rt is the destination
	typedef struct packed {
		logic [NB_OPCODE-1:0] opcode;
		reg_addr_t            rs;
		reg_addr_t            rt;
		logic [NB_IMM-1:0]    imm;
	} i_fields_t;

	// Same 32 bits, opcode picks the view
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_word_t;

endpackage

// File: hw/issue_if.sv
/*
 * Decoded instruction handed from the decoder to the register bank
 * and to the execute stage, one cycle wide
 */
`timescale 1ns/1ps

interface issue_if;

	// Instruction present this cycle
	logic                  valid;
	// Operation and operand selection
	regfile_pkg::alu_op_t  alu_op;
	regfile_pkg::reg_addr_t addr_ra;
	regfile_pkg::reg_addr_t addr_rb;
	regfile_pkg::reg_addr_t addr_dest;
	// Extended immediate, replaces operand b when use_imm is set
	regfile_pkg::word_t    immediate;
	logic                  use_imm;

	modport decoder (
		output valid,
		output alu_op,
		output addr_ra,
		output addr_rb,
		output addr_dest,
		output immediate,
		output use_imm
	);

	// Bank only needs the read addresses
	modport bank (
		input valid,
		input addr_ra,
		input addr_rb
	);

	modport execute (
		input valid,
		input alu_op,
		input addr_ra,
		input addr_rb,
		input addr_dest,
		input immediate,
		input use_imm
	);

endinterface

// File: hw/instr_decoder.sv
/*
 * Instruction decoder: reads the word as R-type or I-type and registers
 * the ALU controls, one decoded instruction per input strobe
 */
`timescale 1ns/1ps

module instr_decoder (
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_valid,
	input  regfile_pkg::instr_word_t i_instruction,
	issue_if.decoder                 o_issue
);

	// Combinational decode results
	logic                   dec_ok;
	regfile_pkg::alu_op_t   dec_op;
	regfile_pkg::reg_addr_t dec_ra;
	regfile_pkg::reg_addr_t dec_rb;
	regfile_pkg::reg_addr_t dec_dest;
	regfile_pkg::word_t     dec_imm;
	logic                   dec_use_imm;

	always_comb
	begin
		// Defaults follow the I-type view
		dec_ok      = 1'b1;
		dec_op      = regfile_pkg::ALU_ADD;
		dec_ra      = i_instruction.i.rs;
		dec_rb      = i_instruction.i.rt;
		dec_dest    = i_instruction.i.rt;
		dec_use_imm = 1'b1;
		// Sign extension unless overridden
		dec_imm     = {{16{i_instruction.i.imm[15]}}, i_instruction.i.imm};

		case (i_instruction.r.opcode)
			regfile_pkg::OPC_RTYPE:
			begin
				// Register view, rd gets the result
				dec_ra      = i_instruction.r.rs;
				dec_rb      = i_instruction.r.rt;
				dec_dest    = i_instruction.r.rd;
				dec_use_imm = 1'b0;
				case (i_instruction.r.funct)
					regfile_pkg::FN_ADD: dec_op = regfile_pkg::ALU_ADD;
					regfile_pkg::FN_SUB: dec_op = regfile_pkg::ALU_SUB;
					regfile_pkg::FN_AND: dec_op = regfile_pkg::ALU_AND;
					regfile_pkg::FN_OR:  dec_op = regfile_pkg::ALU_OR;
					regfile_pkg::FN_XOR: dec_op = regfile_pkg::ALU_XOR;
					regfile_pkg::FN_SLT: dec_op = regfile_pkg::ALU_SLT;
					// Unknown funct is dropped
					default:             dec_ok = 1'b0;
				endcase
			end
			regfile_pkg::OPC_ADDI:
				dec_op = regfile_pkg::ALU_ADD;
			regfile_pkg::OPC_ANDI:
			begin
				dec_op  = regfile_pkg::ALU_AND;
				dec_imm = {16'b0, i_instruction.i.imm};
			end
			regfile_pkg::OPC_ORI:
			begin
				dec_op  = regfile_pkg::ALU_OR;
				dec_imm = {16'b0, i_instruction.i.imm};
			end
			regfile_pkg::OPC_XORI:
			begin
				dec_op  = regfile_pkg::ALU_XOR;
				dec_imm = {16'b0, i_instruction.i.imm};
			end
			regfile_pkg::OPC_LUI:
			begin
				// Immediate lands in the upper half
				dec_op  = regfile_pkg::ALU_LUI;
				dec_imm = {i_instruction.i.imm, 16'b0};
			end
			default:
				dec_ok = 1'b0;
		endcase
	end

	// Issue valid only for a strobed, supported encoding
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_issue.valid <= 1'b0;
		else
			o_issue.valid <= i_valid & dec_ok;
	end

	// Payload fields, qualified by valid
	always_ff @(posedge i_clock)
	begin
		o_issue.alu_op    <= dec_op;
		o_issue.addr_ra   <= dec_ra;
		o_issue.addr_rb   <= dec_rb;
		o_issue.addr_dest <= dec_dest;
		o_issue.immediate <= dec_imm;
		o_issue.use_imm   <= dec_use_imm;
	end

endmodule

// File: hw/register_bank.sv
/*
 * Register bank with two registered read ports; a write to an address being
 * read is passed straight through. Reset loads every register with its index
 */
`timescale 1ns/1ps

module register_bank (
	input  logic                   i_clock,
	input  logic                   i_reset,
	issue_if.bank                  i_issue,
	input  logic                   i_write,
	input  regfile_pkg::reg_addr_t i_write_addr,
	input  regfile_pkg::word_t     i_write_data,
	output regfile_pkg::word_t     o_data_ra,
	output regfile_pkg::word_t     o_data_rb
);

	regfile_pkg::word_t registers [regfile_pkg::N_REGISTER];

	// Write-through hits on either read port
	logic hit_ra;
	logic hit_rb;

	assign hit_ra = i_write && (i_write_addr == i_issue.addr_ra);
	assign hit_rb = i_write && (i_write_addr == i_issue.addr_rb);

	// Storage array, reset to index values
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			for (int idx = 0; idx < regfile_pkg::N_REGISTER; idx++)
				registers[idx] <= regfile_pkg::word_t'(idx);
		end
		else if (i_write)
		begin
			registers[i_write_addr] <= i_write_data;
		end
	end

	// Read port A
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_data_ra <= '0;
		else if (i_issue.valid)
		begin
			// Same-cycle write wins over the stored value
			if (hit_ra)
				o_data_ra <= i_write_data;
			else
				o_data_ra <= registers[i_issue.addr_ra];
		end
	end

	// Read port B, independent of port A
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_data_rb <= '0;
		else if (i_issue.valid)
		begin
			if (hit_rb)
				o_data_rb <= i_write_data;
			else
				o_data_rb <= registers[i_issue.addr_rb];
		end
	end

endmodule

// File: hw/execute_stage.sv
/*
 * Execute stage: lines the issue controls up with the bank operands,
 * forwards its last result, runs the ALU and registers the writeback
 */
`timescale 1ns/1ps

module execute_stage (
	input  logic                   i_clock,
	input  logic                   i_reset,
	issue_if.execute               i_issue,
	input  regfile_pkg::word_t     i_data_ra,
	input  regfile_pkg::word_t     i_data_rb,
	output logic                   o_write,
	output regfile_pkg::reg_addr_t o_write_addr,
	output regfile_pkg::word_t     o_write_data
);

	// Operand-stage copy of the issue controls
	logic                   op_valid;
	regfile_pkg::alu_op_t   op_alu_op;
	regfile_pkg::reg_addr_t op_addr_ra;
	regfile_pkg::reg_addr_t op_addr_rb;
	regfile_pkg::reg_addr_t op_addr_dest;
	regfile_pkg::word_t     op_immediate;
	logic                   op_use_imm;

	// Forwarding selects
	logic fwd_a;
	logic fwd_b;

	// ALU inputs and output
	regfile_pkg::word_t operand_a;
	regfile_pkg::word_t reg_b;
	regfile_pkg::word_t operand_b;
	regfile_pkg::word_t alu_result;

	// Controls land with the bank's read edge
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			op_valid <= 1'b0;
		else
			op_valid <= i_issue.valid;
	end

	always_ff @(posedge i_clock)
	begin
		op_alu_op    <= i_issue.alu_op;
		op_addr_ra   <= i_issue.addr_ra;
		op_addr_rb   <= i_issue.addr_rb;
		op_addr_dest <= i_issue.addr_dest;
		op_immediate <= i_issue.immediate;
		op_use_imm   <= i_issue.use_imm;
	end

	// Previous instruction's result is newer than the bank copy
	assign fwd_a = o_write && (o_write_addr == op_addr_ra);
	assign fwd_b = o_write && (o_write_addr == op_addr_rb);

	assign operand_a = fwd_a ? o_write_data : i_data_ra;
	assign reg_b     = fwd_b ? o_write_data : i_data_rb;
	// Immediate forms ignore rt as a source
	assign operand_b = op_use_imm ? op_immediate : reg_b;

	always_comb
	begin
		case (op_alu_op)
			regfile_pkg::ALU_ADD:
				alu_result = operand_a + operand_b;
			regfile_pkg::ALU_SUB:
				alu_result = operand_a - operand_b;
			regfile_pkg::ALU_AND:
				alu_result = operand_a & operand_b;
			regfile_pkg::ALU_OR:
				alu_result = operand_a | operand_b;
			regfile_pkg::ALU_XOR:
				alu_result = operand_a ^ operand_b;
			regfile_pkg::ALU_SLT:
				// Signed compare, result is 0 or 1
				alu_result = ($signed(operand_a) < $signed(operand_b)) ?
					regfile_pkg::word_t'(1) : '0;
			regfile_pkg::ALU_LUI:
				// Immediate already shifted by the decoder
				alu_result = operand_b;
			default:
				alu_result = '0;
		endcase
	end

	// Writeback strobe, one cycle per operand-stage instruction
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_write <= 1'b0;
		else
			o_write <= op_valid;
	end

	// Result payload
	always_ff @(posedge i_clock)
	begin
		o_write_addr <= op_addr_dest;
		o_write_data <= alu_result;
	end

endmodule

// File: hw/regfile_pipe.sv
/*
 * Top level of the operand and result path: decoder, register bank and
 * execute stage, with the writeback also driven out as the result
 */
`timescale 1ns/1ps

module regfile_pipe (
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_valid,
	input  regfile_pkg::instr_word_t i_instruction,
	output logic                     o_result_valid,
	output regfile_pkg::word_t       o_result,
	output regfile_pkg::reg_addr_t   o_result_addr
);

	// Decoded instruction bus
	issue_if issue ();

	// Bank operands
	regfile_pkg::word_t     data_ra;
	regfile_pkg::word_t     data_rb;

	// Writeback, shared by bank and outputs
	logic                   wb_write;
	regfile_pkg::reg_addr_t wb_addr;
	regfile_pkg::word_t     wb_data;

	instr_decoder instr_decoder_i (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_instruction (i_instruction),
		.o_issue       (issue.decoder)
	);

	register_bank register_bank_i (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_issue      (issue.bank),
		.i_write      (wb_write),
		.i_write_addr (wb_addr),
		.i_write_data (wb_data),
		.o_data_ra    (data_ra),
		.o_data_rb    (data_rb)
	);

	execute_stage execute_stage_i (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_issue      (issue.execute),
		.i_data_ra    (data_ra),
		.i_data_rb    (data_rb),
		.o_write      (wb_write),
		.o_write_addr (wb_addr),
		.o_write_data (wb_data)
	);

	// Result port mirrors the writeback
	assign o_result_valid = wb_write;
	assign o_result       = wb_data;
	assign o_result_addr  = wb_addr;

endmodule

// File: dv/regfile_pipe_assert.sv
/*
 * Writeback checks for the execute stage, bound into every instance
 */
`timescale 1ns/1ps

module regfile_pipe_assert (
	input logic               i_clock,
	input logic               i_reset,
	input logic               i_op_valid,
	input logic               i_write,
	input regfile_pkg::word_t i_write_data
);

	// Write strobe is low the cycle after a reset edge
	write_low_after_reset: assert property (
		@(posedge i_clock) i_reset |=> !i_write
	) else $error("write strobe high in the cycle after reset");

	// Data on a write must be fully known
	write_data_known: assert property (
		@(posedge i_clock) disable iff (i_reset) i_write |-> !$isunknown(i_write_data)
	) else $error("write data has unknown bits while write is high");

	// Operand-stage valid reaches the writeback one edge later
	write_follows_valid: assert property (
		@(posedge i_clock) disable iff (i_reset) i_op_valid |=> i_write
	) else $error("operand-stage instruction produced no write one edge later");

endmodule

bind execute_stage regfile_pipe_assert regfile_pipe_assert_i (
	.i_clock      (i_clock),
	.i_reset      (i_reset),
	.i_op_valid   (op_valid),
	.i_write      (o_write),
	.i_write_data (o_write_data)
);

// File: dv/regfile_pipe_tb.sv
/*
 * Testbench for the register bank pipeline: LCG instruction stream,
 * sequential reference model and in-order result compare
 */
`timescale 1ns/1ps

module regfile_pipe_tb;

	// 400 instructions at up to 4 cycles each, plus reset and drain
	localparam int TIMEOUT_CYCLES = 2000;

	logic                     i_clock;
	logic                     i_reset;
	logic                     i_valid;
	regfile_pkg::instr_word_t i_instruction;
	logic                     o_result_valid;
	regfile_pkg::word_t       o_result;
	regfile_pkg::reg_addr_t   o_result_addr;

	// Sequential view of the register file
	regfile_pkg::word_t ref_regs [regfile_pkg::N_REGISTER];

	// Expected results in issue order
	regfile_pkg::word_t     result_q [$];
	regfile_pkg::reg_addr_t addr_q [$];
	string                  name_q [$];

	logic [31:0]            rng_state = 32'hc6aa;
	int                     cycle_count = 0;
	int                     checked_count = 0;

	// Stimulus and compare scratch
	logic [31:0]            stim_rnd;
	logic [31:0]            stim_extra;
	regfile_pkg::reg_addr_t stim_addr;
	regfile_pkg::instr_word_t stim_instr;
	string                  cmp_name;
	regfile_pkg::word_t     cmp_result;
	regfile_pkg::reg_addr_t cmp_addr;

	regfile_pipe regfile_pipe_i (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_valid        (i_valid),
		.i_instruction  (i_instruction),
		.o_result_valid (o_result_valid),
		.o_result       (o_result),
		.o_result_addr  (o_result_addr)
	);

	initial i_clock = 1'b0;
	always #20 i_clock = ~i_clock;

	// LCG step, upper bits folded down into the weak low bits
	function automatic logic [31:0] draw_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state ^ (rng_state >> 15);
	endfunction

	function automatic regfile_pkg::instr_word_t build_rtype(input logic [5:0] funct,
			input regfile_pkg::reg_addr_t rs, input regfile_pkg::reg_addr_t rt,
			input regfile_pkg::reg_addr_t rd);
		regfile_pkg::instr_word_t instr;
		instr.r = '{opcode: regfile_pkg::OPC_RTYPE, rs: rs, rt: rt, rd: rd,
			shamt: 5'd0, funct: funct};
		return instr;
	endfunction

	function automatic regfile_pkg::instr_word_t build_itype(input logic [5:0] opcode,
			input regfile_pkg::reg_addr_t rs, input regfile_pkg::reg_addr_t rt,
			input logic [15:0] imm);
		regfile_pkg::instr_word_t instr;
		instr.i = '{opcode: opcode, rs: rs, rt: rt, imm: imm};
		return instr;
	endfunction

	// 6 and 7 weight SLT and SUB a little more
	function automatic logic [5:0] pick_funct(input logic [2:0] sel);
		case (sel)
			3'd0:    return regfile_pkg::FN_ADD;
			3'd1:    return regfile_pkg::FN_SUB;
			3'd2:    return regfile_pkg::FN_AND;
			3'd3:    return regfile_pkg::FN_OR;
			3'd4:    return regfile_pkg::FN_XOR;
			3'd7:    return regfile_pkg::FN_SUB;
			default: return regfile_pkg::FN_SLT;
		endcase
	endfunction

	function automatic logic [5:0] pick_iop(input logic [2:0] sel);
		case (sel)
			3'd1:    return regfile_pkg::OPC_ANDI;
			3'd2:    return regfile_pkg::OPC_ORI;
			3'd3:    return regfile_pkg::OPC_XORI;
			3'd4:    return regfile_pkg::OPC_LUI;
			default: return regfile_pkg::OPC_ADDI;
		endcase
	endfunction

	// Narrow mode keeps every register in 4..7 so hazards are common
	function automatic regfile_pkg::instr_word_t random_instruction(input logic [31:0] rnd,
			input logic [15:0] imm, input logic narrow);
		regfile_pkg::reg_addr_t rs;
		regfile_pkg::reg_addr_t rt;
		regfile_pkg::reg_addr_t rd;
		rs = narrow ? {3'b001, rnd[1:0]} : rnd[4:0];
		rt = narrow ? {3'b001, rnd[6:5]} : rnd[9:5];
		rd = narrow ? {3'b001, rnd[11:10]} : rnd[14:10];
		if (rnd[31])
			return build_rtype(pick_funct(rnd[18:16]), rs, rt, rd);
		else
			return build_itype(pick_iop(rnd[21:19]), rs, rt, imm);
	endfunction

	// Reference model, returns 0 for an encoding that gives no result
	function automatic logic predict(input regfile_pkg::instr_word_t instr,
			output regfile_pkg::word_t result, output regfile_pkg::reg_addr_t dest);
		regfile_pkg::word_t src_a;
		regfile_pkg::word_t src_b;
		logic [15:0]        imm;
		logic               supported;
		src_a     = ref_regs[instr.r.rs];
		src_b     = ref_regs[instr.r.rt];
		imm       = instr.i.imm;
		supported = 1'b1;
		result    = '0;
		dest      = instr.i.rt;
		case (instr.r.opcode)
			regfile_pkg::OPC_RTYPE:
			begin
				dest = instr.r.rd;
				case (instr.r.funct)
					regfile_pkg::FN_ADD: result = src_a + src_b;
					regfile_pkg::FN_SUB: result = src_a - src_b;
					regfile_pkg::FN_AND: result = src_a & src_b;
					regfile_pkg::FN_OR:  result = src_a | src_b;
					regfile_pkg::FN_XOR: result = src_a ^ src_b;
					regfile_pkg::FN_SLT:
						result = ($signed(src_a) < $signed(src_b)) ? 32'd1 : 32'd0;
					default:             supported = 1'b0;
				endcase
			end
			regfile_pkg::OPC_ADDI: result = src_a + {{16{imm[15]}}, imm};
			regfile_pkg::OPC_ANDI: result = src_a & {16'h0000, imm};
			regfile_pkg::OPC_ORI:  result = src_a | {16'h0000, imm};
			regfile_pkg::OPC_XORI: result = src_a ^ {16'h0000, imm};
			regfile_pkg::OPC_LUI:  result = {imm, 16'h0000};
			default:               supported = 1'b0;
		endcase
		return supported;
	endfunction

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input regfile_pkg::word_t expected,
			input regfile_pkg::word_t actual);
		if (actual !== expected)
		begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input regfile_pkg::reg_addr_t expected,
			input regfile_pkg::reg_addr_t actual);
		if (actual !== expected)
		begin
			$display("error %s: expected addr %0d, actual addr %0d", name, expected, actual);
			abort_run();
		end
	endtask

	// One strobe, expected result queued in program order
	task automatic drive_instruction(input string name, input regfile_pkg::instr_word_t instr);
		regfile_pkg::word_t     result;
		regfile_pkg::reg_addr_t dest;
		@(posedge i_clock);
		i_valid       <= 1'b1;
		i_instruction <= instr;
		if (predict(instr, result, dest))
		begin
			ref_regs[dest] = result;
			result_q.push_back(result);
			addr_q.push_back(dest);
			name_q.push_back(name);
		end
	endtask

	// Junk on the instruction bus while valid is low
	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			@(posedge i_clock);
			i_valid       <= 1'b0;
			i_instruction <= regfile_pkg::instr_word_t'(draw_random());
		end
	endtask

	// About one slot in four gets a gap of 1 to 3 cycles
	task automatic maybe_gap();
		logic [31:0] rnd;
		rnd = draw_random();
		if (rnd[31:30] == 2'b00)
			idle_cycles(1 + int'(rnd[29:28] % 2'd3));
	endtask

	initial
	begin
		i_reset       = 1'b1;
		i_valid       = 1'b0;
		i_instruction = '0;
		for (int idx = 0; idx < regfile_pkg::N_REGISTER; idx++)
			ref_regs[idx] = regfile_pkg::word_t'(idx);

		repeat (10) @(posedge i_clock);
		i_reset <= 1'b0;

		// Reset contents, OR of each register with itself
		for (int idx = 0; idx < regfile_pkg::N_REGISTER; idx++)
		begin
			stim_addr = regfile_pkg::reg_addr_t'(idx);
			stim_instr = build_rtype(regfile_pkg::FN_OR, stim_addr, stim_addr, stim_addr);
			drive_instruction("reset_contents", stim_instr);
			maybe_gap();
		end

		// Random full words via LUI then ORI, back to back
		for (int idx = 0; idx < regfile_pkg::N_REGISTER; idx++)
		begin
			stim_addr  = regfile_pkg::reg_addr_t'(idx);
			stim_rnd   = draw_random();
			stim_extra = draw_random();
			drive_instruction("load_upper", build_itype(regfile_pkg::OPC_LUI, stim_rnd[4:0],
				stim_addr, stim_rnd[31:16]));
			drive_instruction("load_lower", build_itype(regfile_pkg::OPC_ORI, stim_addr,
				stim_addr, stim_extra[31:16]));
			maybe_gap();
		end

		for (int n = 0; n < 64; n++)
		begin
			stim_rnd = draw_random();
			drive_instruction("rtype_ops", build_rtype(pick_funct(stim_rnd[18:16]),
				stim_rnd[4:0], stim_rnd[9:5], stim_rnd[14:10]));
			maybe_gap();
		end

		for (int n = 0; n < 80; n++)
		begin
			stim_rnd   = draw_random();
			stim_extra = draw_random();
			drive_instruction("itype_ops", build_itype(pick_iop(stim_rnd[21:19]),
				stim_rnd[4:0], stim_rnd[9:5], stim_extra[31:16]));
			maybe_gap();
		end

		// Dependent chains over four registers
		for (int n = 0; n < 112; n++)
		begin
			stim_rnd   = draw_random();
			stim_extra = draw_random();
			drive_instruction("hazards", random_instruction(stim_rnd, stim_extra[31:16], 1'b1));
			maybe_gap();
		end

		// Unsupported opcodes and functts mixed with valid work
		for (int n = 0; n < 48; n++)
		begin
			stim_rnd   = draw_random();
			stim_extra = draw_random();
			case (stim_rnd[23:22])
				2'd0: stim_instr = regfile_pkg::instr_word_t'(stim_extra);
				2'd1: stim_instr = build_rtype(stim_extra[5:0], stim_rnd[4:0],
					stim_rnd[9:5], stim_rnd[14:10]);
				default: stim_instr = random_instruction(stim_rnd, stim_extra[31:16], 1'b0);
			endcase
			drive_instruction("unsupported_mix", stim_instr);
			maybe_gap();
		end

		idle_cycles(8);
		if (result_q.size() != 0)
		begin
			$display("%0d expected results never came out of the pipeline", result_q.size());
			abort_run();
		end
		else
		begin
			$display("checked %0d results", checked_count);
			$display("TEST OK");
			$finish;
		end
	end

	// Outputs settle after the rising edge, compare mid-cycle
	always @(negedge i_clock)
	begin
		if (!i_reset && o_result_valid)
		begin
			if (result_q.size() == 0)
			begin
				$display("result for register %0d appeared with nothing expected", o_result_addr);
				abort_run();
			end
			else
			begin
				cmp_name   = name_q.pop_front();
				cmp_result = result_q.pop_front();
				cmp_addr   = addr_q.pop_front();
				check_word(cmp_name, cmp_result, o_result);
				check_addr(cmp_name, cmp_addr, o_result_addr);
				checked_count++;
			end
		end
	end

	always @(posedge i_clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the run did not finish", cycle_count);
			abort_run();
		end
	end

endmodule

// File: regfile_pipe.f
hw/regfile_pkg.sv
hw/issue_if.sv
hw/instr_decoder.sv
hw/register_bank.sv
hw/execute_stage.sv
hw/regfile_pipe.sv
dv/regfile_pipe_assert.sv
dv/regfile_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the regfile_pipe testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
	-f regfile_pipe.f \
	--top-module regfile_pipe_tb \
	-Mdir "$BUILD_DIR" \
	-o regfile_pipe_sim

# A failing run exits non-zero, the log search below decides the result
"./$BUILD_DIR/regfile_pipe_sim" > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -q "TEST FAILED" "$LOG_FILE"; then
	exit 1
fi
# An assertion stop ends the run before either message
if ! grep -q "TEST OK" "$LOG_FILE"; then
	exit 1
fi
exit 0
